// ==== verilog/mips_consts.svh ====
// MIPS core constants
// widths, reset PC, primary opcodes and R-type function codes
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN      32            // data and address width
`define MIPS_REG_AW    5             // register index width
`define MIPS_RESET_PC  32'h0040_0000 // first fetch address

`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_ADDI   6'h08
`define MIPS_OP_LW     6'h23
`define MIPS_OP_SW     6'h2b
`define MIPS_OP_BEQ    6'h04

`define MIPS_FN_ADD    6'h20
`define MIPS_FN_SUB    6'h22
`define MIPS_FN_AND    6'h24
`define MIPS_FN_OR     6'h25
`define MIPS_FN_SLT    6'h2a

`endif

// ==== verilog/mips_pkg.sv ====
// MIPS core types
// control bundle, ALU and forwarding selects, pipeline stage registers
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;  // write back load data
        logic    alu_src_imm; // operand b from immediate
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef enum logic [1:0] {
        fwd_reg,     // value read in decode
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_e;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`MIPS_XLEN-1:0]   pc_plus4;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
        logic [`MIPS_REG_AW-1:0] rs_idx;
        logic [`MIPS_REG_AW-1:0] rt_idx;
        logic [`MIPS_REG_AW-1:0] rd_idx;
        logic [`MIPS_XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`MIPS_XLEN-1:0]   alu_result;
        logic [`MIPS_XLEN-1:0]   store_data;
        logic [`MIPS_REG_AW-1:0] rd_idx;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`MIPS_XLEN-1:0]   alu_result;
        logic [`MIPS_XLEN-1:0]   load_data;
        logic [`MIPS_REG_AW-1:0] rd_idx;
    } mem_wb_t;

endpackage

// ==== verilog/mips_decoder.sv ====
// Instruction decoder
// opcode/funct to control bits, register fields and sign-extended immediate
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_decoder (
    input  logic [`MIPS_XLEN-1:0]   instr,
    output mips_pkg::ctrl_t         ctrl,
    output logic [`MIPS_REG_AW-1:0] rs,
    output logic [`MIPS_REG_AW-1:0] rt,
    output logic [`MIPS_REG_AW-1:0] rd_dest,
    output logic [`MIPS_XLEN-1:0]   imm
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign imm    = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

    always_comb
    begin
        ctrl    = '0;          // bubble unless recognised
        rd_dest = instr[20:16]; // I-type writes rt
        case (opcode)
            `MIPS_OP_RTYPE:
            begin
                rd_dest        = instr[15:11];
                ctrl.reg_write = 1'b1;
                case (funct)
                    `MIPS_FN_ADD: ctrl.alu_op = alu_add;
                    `MIPS_FN_SUB: ctrl.alu_op = alu_sub;
                    `MIPS_FN_AND: ctrl.alu_op = alu_and;
                    `MIPS_FN_OR:  ctrl.alu_op = alu_or;
                    `MIPS_FN_SLT: ctrl.alu_op = alu_slt;
                    default:      ctrl        = '0; // includes the all-zero nop
                endcase
            end
            `MIPS_OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            `MIPS_OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            `MIPS_OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            `MIPS_OP_BEQ:
            begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub; // equal when difference is zero
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== verilog/mips_regfile.sv ====
// Register file
// 32 words, two read ports with write-through, one write port, r0 fixed at zero
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_regfile (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic [`MIPS_REG_AW-1:0] rs_idx,
    input  logic [`MIPS_REG_AW-1:0] rt_idx,
    output logic [`MIPS_XLEN-1:0]   rs_val,
    output logic [`MIPS_XLEN-1:0]   rt_val,
    input  logic                    wr_en,
    input  logic [`MIPS_REG_AW-1:0] wr_idx,
    input  logic [`MIPS_XLEN-1:0]   wr_data
);
    logic [`MIPS_XLEN-1:0] regs [0:(1<<`MIPS_REG_AW)-1];
    logic                  wr_active;

    assign wr_active = wr_en && (wr_idx != '0); // r0 never written

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < (1 << `MIPS_REG_AW); i++)
                regs[i] <= '0;
        end
        else if (wr_active)
            regs[wr_idx] <= wr_data;
    end

    assign rs_val = (wr_active && wr_idx == rs_idx) ? wr_data : regs[rs_idx]; // bypass
    assign rt_val = (wr_active && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

// ==== verilog/mips_hazard_unit.sv ====
// Hazard unit
// load-use stall detection and forwarding selects for the execute operands
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_hazard_unit (
    input  logic [`MIPS_REG_AW-1:0] id_rs,
    input  logic [`MIPS_REG_AW-1:0] id_rt,
    input  mips_pkg::id_ex_t        id_ex,
    input  mips_pkg::ex_mem_t       ex_mem,
    input  mips_pkg::mem_wb_t       mem_wb,
    output logic                    load_stall,
    output mips_pkg::fwd_sel_e      fwd_a,
    output mips_pkg::fwd_sel_e      fwd_b
);
    import mips_pkg::*;

    logic ex_mem_writes;
    logic mem_wb_writes;

    // younger writer wins and r0 is never forwarded
    function automatic fwd_sel_e pick_src(input logic [`MIPS_REG_AW-1:0] src);
        if (ex_mem_writes && ex_mem.rd_idx == src)
            return fwd_ex_mem;
        else if (mem_wb_writes && mem_wb.rd_idx == src)
            return fwd_mem_wb;
        return fwd_reg;
    endfunction

    assign ex_mem_writes = ex_mem.ctrl.reg_write && (ex_mem.rd_idx != '0);
    assign mem_wb_writes = mem_wb.ctrl.reg_write && (mem_wb.rd_idx != '0);

    // load in EX feeding the instruction in ID (rt checked even if unused)
    assign load_stall = id_ex.ctrl.mem_read
                     && (id_ex.rd_idx != '0)
                     && (id_ex.rd_idx == id_rs || id_ex.rd_idx == id_rt);

    always_comb
    begin
        fwd_a = pick_src(id_ex.rs_idx);
        fwd_b = pick_src(id_ex.rt_idx);
    end

endmodule

// ==== verilog/mips_alu.sv ====
// Integer ALU
// add, sub, and, or, signed set-less-than; zero flag drives beq
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_alu (
    input  mips_pkg::alu_op_e     op,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);
    import mips_pkg::*;

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {{(`MIPS_XLEN-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // a == b under alu_sub

endmodule

// ==== verilog/mips_core.sv ====
// MIPS five-stage pipelined core
// fetch, decode, execute, memory, write-back with forwarding, load-use stall,
// beq resolved in execute and a Wishbone classic data master
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_core (
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    output logic [`MIPS_XLEN-1:0]       imem_addr,
    input  logic [`MIPS_XLEN-1:0]       imem_data,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [`MIPS_XLEN-1:0]       wb_adr,
    output logic [`MIPS_XLEN-1:0]       wb_dat_w,
    output logic [`MIPS_XLEN/8-1:0]     wb_sel,
    input  logic [`MIPS_XLEN-1:0]       wb_dat_r,
    input  logic                        wb_ack
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0]   pc;
    logic [`MIPS_XLEN-1:0]   pc_plus4;
    logic [`MIPS_XLEN-1:0]   if_id_instr;
    logic [`MIPS_XLEN-1:0]   if_id_pc4;
    ctrl_t                   dec_ctrl;
    logic [`MIPS_REG_AW-1:0] dec_rs;
    logic [`MIPS_REG_AW-1:0] dec_rt;
    logic [`MIPS_REG_AW-1:0] dec_rd;
    logic [`MIPS_XLEN-1:0]   dec_imm;
    logic [`MIPS_XLEN-1:0]   rf_rs_val;
    logic [`MIPS_XLEN-1:0]   rf_rt_val;
    id_ex_t                  id_ex;
    ex_mem_t                 ex_mem;
    mem_wb_t                 mem_wb;
    logic                    load_stall;
    fwd_sel_e                fwd_a;
    fwd_sel_e                fwd_b;
    logic [`MIPS_XLEN-1:0]   op_a;
    logic [`MIPS_XLEN-1:0]   op_b_reg;
    logic [`MIPS_XLEN-1:0]   alu_result;
    logic                    alu_zero;
    logic                    branch_taken;
    logic [`MIPS_XLEN-1:0]   branch_target;
    logic                    mem_access;
    logic                    mem_wait;
    logic [`MIPS_XLEN-1:0]   wb_data;

    function automatic logic [`MIPS_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                      input logic [`MIPS_XLEN-1:0] reg_val);
        case (sel)
            fwd_ex_mem: return ex_mem.alu_result;
            fwd_mem_wb: return wb_data;
            default:    return reg_val;
        endcase
    endfunction

    // fetch
    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // the slave stalls everything until it acks
    assign mem_access = ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write;
    assign mem_wait   = mem_access && !wb_ack;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc          <= `MIPS_RESET_PC;
            if_id_instr <= '0;
            if_id_pc4   <= '0;
        end
        else if (!mem_wait)
        begin
            if (branch_taken)
            begin
                pc          <= branch_target;
                if_id_instr <= '0; // flush wrong-path fetch
            end
            else if (!load_stall)
            begin
                pc          <= pc_plus4;
                if_id_instr <= imem_data;
                if_id_pc4   <= pc_plus4;
            end
        end
    end

    // decode
    mips_decoder u_decoder (
        .instr   (if_id_instr),
        .ctrl    (dec_ctrl),
        .rs      (dec_rs),
        .rt      (dec_rt),
        .rd_dest (dec_rd),
        .imm     (dec_imm)
    );

    mips_regfile u_regfile (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_idx    (dec_rs),
        .rt_idx    (dec_rt),
        .rs_val    (rf_rs_val),
        .rt_val    (rf_rt_val),
        .wr_en     (mem_wb.ctrl.reg_write),
        .wr_idx    (mem_wb.rd_idx),
        .wr_data   (wb_data)
    );

    mips_hazard_unit u_hazard_unit (
        .id_rs      (dec_rs),
        .id_rt      (dec_rt),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .load_stall (load_stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex <= '0;
        else if (!mem_wait)
        begin
            if (branch_taken || load_stall)
                id_ex <= '0; // bubble
            else
                id_ex <= '{ctrl: dec_ctrl, pc_plus4: if_id_pc4,
                           rs_val: rf_rs_val, rt_val: rf_rt_val,
                           rs_idx: dec_rs, rt_idx: dec_rt, rd_idx: dec_rd,
                           imm: dec_imm};
        end
    end

    // execute
    always_comb
    begin
        op_a     = fwd_mux(fwd_a, id_ex.rs_val);
        op_b_reg = fwd_mux(fwd_b, id_ex.rt_val); // also the store data
    end

    mips_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (op_a),
        .b      (id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_reg),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign branch_taken  = id_ex.ctrl.branch && alu_zero;
    assign branch_target = id_ex.pc_plus4 + {id_ex.imm[`MIPS_XLEN-3:0], 2'b00};

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else if (!mem_wait)
            ex_mem <= '{ctrl: id_ex.ctrl, alu_result: alu_result,
                        store_data: op_b_reg, rd_idx: id_ex.rd_idx};
    end

    // memory stage request held while frozen
    assign wb_cyc   = mem_access;
    assign wb_stb   = mem_access;
    assign wb_we    = ex_mem.ctrl.mem_write;
    assign wb_adr   = ex_mem.alu_result;
    assign wb_dat_w = ex_mem.store_data;
    assign wb_sel   = '1;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_wb <= '0;
        else if (!mem_wait)
            mem_wb <= '{ctrl: ex_mem.ctrl, alu_result: ex_mem.alu_result,
                        load_data: wb_dat_r, rd_idx: ex_mem.rd_idx}; // load data taken with ack
    end

    // write-back
    assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== test/tb_mips_core.sv ====
// Testbench for the MIPS five-stage core
// runs the program from the cases file against instruction and Wishbone data
// memory models with random wait states and checks every store in order
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_mips_core;

    logic                    SYS_clk = 1'b0;
    logic                    SYS_reset = 1'b1;
    logic [`MIPS_XLEN-1:0]   imem_addr;
    logic [`MIPS_XLEN-1:0]   imem_data;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`MIPS_XLEN-1:0]   wb_adr;
    logic [`MIPS_XLEN-1:0]   wb_dat_w;
    logic [`MIPS_XLEN/8-1:0] wb_sel;
    logic [`MIPS_XLEN-1:0]   wb_dat_r;
    logic                    wb_ack;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] imem_off;
    logic [31:0] held_adr;
    logic [31:0] held_dat;
    logic        held_we;
    logic        busy;
    int          n_prog;
    int          n_seen;
    int          errors;
    int          cycles;
    int          timeout_cycles;
    int          wait_left;

    mips_core u_mips_core (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    always #4 SYS_clk = ~SYS_clk; // 8 ns period

    // instruction memory returns nop outside the loaded program
    assign imem_off  = imem_addr - `MIPS_RESET_PC;
    assign imem_data = (imem_off < 32'd1024) ? imem[imem_off[9:2]] : '0;

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        if (dmem.exists(adr))
            return dmem[adr];
        return adr ^ 32'hc3a5_5a3c; // untouched words
    endfunction

    task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
        if (n_seen >= exp_adr.size())
        begin
            errors++;
            $display("unexpected store of %h to address %h after the last expected store",
                     dat, adr);
        end
        else if (adr != exp_adr[n_seen] || dat != exp_dat[n_seen])
        begin
            errors++;
            $display("FAILED store %0d: expected adr %h data %h, actual adr %h data %h",
                     n_seen, exp_adr[n_seen], exp_dat[n_seen], adr, dat);
        end
        n_seen++;
    endtask

    // Wishbone slave serves one request at a time with a one-cycle ack
    always @(negedge SYS_clk)
    begin
        if (SYS_reset || wb_ack)
        begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (wb_sel !== {(`MIPS_XLEN/8){1'b1}})
            begin
                errors++;
                $display("FAILED wb_sel: expected %h, actual %h",
                         {(`MIPS_XLEN/8){1'b1}}, wb_sel);
            end
            if (!busy)
            begin
                busy      = 1'b1;
                held_adr  = wb_adr;
                held_dat  = wb_dat_w;
                held_we   = wb_we;
                wait_left = int'($urandom_range(3, 0));
            end
            else if (wb_adr != held_adr || wb_we != held_we || (held_we && wb_dat_w != held_dat))
            begin
                errors++;
                $display("request changed while waiting for ack at cycle %0d", cycles);
            end
            if (wait_left == 0)
            begin
                wb_ack = 1'b1;
                if (wb_we)
                begin
                    dmem[wb_adr] = wb_dat_w;
                    check_store(wb_adr, wb_dat_w);
                end
                else
                    wb_dat_r = read_word(wb_adr);
            end
            else
                wait_left--;
        end
    end

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] v0;
        logic [31:0] v1;
        fd = $fopen("test/mips_cases.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open the cases file test/mips_cases.txt");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() < 2)
                continue;
            kind = line.getc(0);
            n    = $sscanf(line.substr(1, line.len() - 1), "%h %h", v0, v1);
            case (kind)
                "I":
                begin
                    imem[n_prog] = v0; // consecutive words from the reset PC
                    n_prog++;
                end
                "D": dmem[v0] = v1;
                "S":
                begin
                    exp_adr.push_back(v0);
                    exp_dat.push_back(v1);
                end
                "#":
                begin
                end
                default:
                begin
                    errors++;
                    $display("unknown record in the cases file: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial
    begin
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        busy     = 1'b0;
        n_prog   = 0;
        n_seen   = 0;
        errors   = 0;
        cycles   = 0;
        void'($urandom(1723));
        for (int i = 0; i < 256; i++)
            imem[i] = '0;
        load_cases();
        timeout_cycles = n_prog * 40 + exp_adr.size() * 4;

        repeat (4) @(negedge SYS_clk);
        if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0)
        begin
            errors++;
            $display("FAILED reset_state: expected cyc/stb/we 000, actual %b%b%b",
                     wb_cyc, wb_stb, wb_we);
        end
        if (imem_addr !== `MIPS_RESET_PC)
        begin
            errors++;
            $display("FAILED reset_pc: expected %h, actual %h", `MIPS_RESET_PC, imem_addr);
        end
        SYS_reset = 1'b0;

        while (n_seen < exp_adr.size() && cycles < timeout_cycles)
        begin
            @(negedge SYS_clk);
            cycles++;
        end
        if (n_seen < exp_adr.size())
        begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d expected stores seen",
                     cycles, n_seen, exp_adr.size());
        end
        else
            repeat (10) @(negedge SYS_clk); // room for a stray extra store
        $display("stores seen: %0d, expected: %0d, errors: %0d", n_seen, exp_adr.size(), errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== test/mips_cases.txt ====
# I <word>: program word, in order from the reset PC
# D <addr> <data>: initial data memory word; S <addr> <data>: expected store, in order
I 20010005 addi r1, r0, 5
I 20220003 addi r2, r1, 3
I 00221820 add  r3, r1, r2
I 00612022 sub  r4, r3, r1
I 00832824 and  r5, r4, r3
I 00a13025 or   r6, r5, r1
I 0023382a slt  r7, r1, r3
I 20090100 addi r9, r0, 0x100
I ad230000 sw   r3, 0(r9)
I ad240004 sw   r4, 4(r9)
I ad250008 sw   r5, 8(r9)
I ad26000c sw   r6, 12(r9)
I ad270010 sw   r7, 16(r9)
I 2008ffff addi r8, r0, -1
I 0101502a slt  r10, r8, r1
I ad2a0014 sw   r10, 20(r9)
I 8d2b0040 lw   r11, 0x40(r9)
I 01616020 add  r12, r11, r1
I ad2c0018 sw   r12, 24(r9)
I 10210002 beq  r1, r1, +2
I ad21001c sw   r1, 28(r9)
I ad23001c sw   r3, 28(r9)
I 10220005 beq  r1, r2, +5
I ad22001c sw   r2, 28(r9)
I 00220020 add  r0, r1, r2
I ad200020 sw   r0, 32(r9)
I 8d2d0000 lw   r13, 0(r9)
I 01a27022 sub  r14, r13, r2
I ad2e0024 sw   r14, 36(r9)
D 00000140 00001000
S 00000100 0000000d
S 00000104 00000008
S 00000108 00000008
S 0000010c 0000000d
S 00000110 00000001
S 00000114 00000001
S 00000118 00001005
S 0000011c 00000008
S 00000120 00000000
S 00000124 00000005

// ==== project.f ====
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_decoder.sv
verilog/mips_regfile.sv
verilog/mips_hazard_unit.sv
verilog/mips_alu.sv
verilog/mips_core.sv
test/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the MIPS core testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mips_core -o sim_mips \
    && ./obj_dir/sim_mips > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "All tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
